/* r5p_consts.svh */
// shared sizes for the rv32 load/store path
// XLEN is fixed at 32, so no rv64 widths exist anywhere
// memory depth counts 32-bit words and must be a power of two
`ifndef R5P_CONSTS_SVH
`define R5P_CONSTS_SVH

//////////////////////////////
// core widths
//////////////////////////////

// register and data width
`define R5P_XLEN 32

// bus address width, byte addressed
`define R5P_AW 32

//////////////////////////////
// data memory
//////////////////////////////

`define R5P_MEM_WORDS 256

`endif

/* riscv_isa_pkg.sv */
// rv32 encodings needed by the load/store path only
// funct3 values of loads and stores overlap, as in the ISA, so they are
// plain constants and not an enum
`default_nettype none

package riscv_isa_pkg;

  //////////////////////////////
  // major opcode
  //////////////////////////////

  // anything that is not a load or store collapses to OTHER
  typedef enum logic [6:0] {
    OTHER = 7'b000_0000,
    LOAD  = 7'b000_0011,
    STORE = 7'b010_0011
  } opc_t;

  //////////////////////////////
  // funct3 for loads and stores
  //////////////////////////////

  typedef logic [2:0] lsu_f3_t;

  // loads
  localparam lsu_f3_t LB  = 3'b000;
  localparam lsu_f3_t LH  = 3'b001;
  localparam lsu_f3_t LW  = 3'b010;
  localparam lsu_f3_t LBU = 3'b100;
  localparam lsu_f3_t LHU = 3'b101;

  // stores
  localparam lsu_f3_t SB  = 3'b000;
  localparam lsu_f3_t SH  = 3'b001;
  localparam lsu_f3_t SW  = 3'b010;

  //////////////////////////////
  // instruction word
  //////////////////////////////

  // same 32 bits, decoded as I-type for loads and S-type for stores
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      lsu_f3_t     f3;
      logic [4:0]  rd;
      logic [6:0]  opc;
    } itype;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      lsu_f3_t     f3;
      logic [4:0]  imm_lo;
      logic [6:0]  opc;
    } stype;
  } ins_t;

endpackage

`default_nettype wire

/* r5p_ctl_pkg.sv */
// decoded control of one load/store instruction
// rd only carries meaning for loads
`default_nettype none

package r5p_ctl_pkg;

  //////////////////////////////
  // decoder to lsu control
  //////////////////////////////

  typedef struct packed {
    // major opcode, already reduced to LOAD/STORE/OTHER
    riscv_isa_pkg::opc_t    opc;
    // store when set
    logic                   we;
    // access size and sign
    riscv_isa_pkg::lsu_f3_t f3;
    // load destination
    logic [4:0]             rd;
  } ctl_t;

endpackage

`default_nettype wire

/* r5p_ls_decoder.sv */
// combinational load/store decoder
// effective address is rs1 plus the sign-extended I or S immediate
// non load/store opcodes give OTHER with a zero immediate
`default_nettype none
`include "r5p_consts.svh"

module r5p_ls_decoder (
  input  riscv_isa_pkg::ins_t    ins,
  input  logic [`R5P_XLEN-1:0]   rs1_val,
  input  logic [`R5P_XLEN-1:0]   rs2_val,
  output riscv_isa_pkg::opc_t    ctl_opc,
  output logic                   ctl_we,
  output riscv_isa_pkg::lsu_f3_t ctl_f3,
  output logic [4:0]             ctl_rd,
  output logic [`R5P_XLEN-1:0]   adr,
  output logic [`R5P_XLEN-1:0]   wdt
);

  r5p_ctl_pkg::ctl_t    ctl;
  logic [11:0]          imm;
  logic [`R5P_XLEN-1:0] imm_sx;

  //////////////////////////////
  // opcode and immediate select
  //////////////////////////////

  always_comb begin
    // defaults cover every non memory opcode
    ctl.opc = riscv_isa_pkg::OTHER;
    ctl.we  = 1'b0;
    // funct3 sits at the same bits in both views
    ctl.f3  = ins.itype.f3;
    ctl.rd  = 5'd0;
    imm     = 12'd0;
    case (ins.itype.opc)
      riscv_isa_pkg::LOAD: begin
        ctl.opc = riscv_isa_pkg::LOAD;
        ctl.rd  = ins.itype.rd;
        imm     = ins.itype.imm;
      end
      riscv_isa_pkg::STORE: begin
        ctl.opc = riscv_isa_pkg::STORE;
        ctl.we  = 1'b1;
        // S-type splits the immediate around rs1/rs2
        imm     = {ins.stype.imm_hi, ins.stype.imm_lo};
      end
      default: begin
        ctl.opc = riscv_isa_pkg::OTHER;
      end
    endcase
  end

  // sign extend to register width
  assign imm_sx = {{(`R5P_XLEN-12){imm[11]}}, imm};

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign adr = rs1_val + imm_sx;

  // store data goes out unshifted, the lsu places it
  assign wdt = rs2_val;

  assign ctl_opc = ctl.opc;
  assign ctl_we  = ctl.we;
  assign ctl_f3  = ctl.f3;
  assign ctl_rd  = ctl.rd;

endmodule

`default_nettype wire

/* r5p_lsu.sv */
// load/store unit, rv32 only, misaligned accesses trap and never reach the bus
// request is held by the core until rdy, bus request until ls_rdy
// read data is expected one cycle after a read transfer
`default_nettype none
`include "r5p_consts.svh"

module r5p_lsu (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ins_vld,
  input  riscv_isa_pkg::opc_t    ctl_opc,
  input  logic                   ctl_we,
  input  riscv_isa_pkg::lsu_f3_t ctl_f3,
  input  logic [`R5P_XLEN-1:0]   adr,
  input  logic [`R5P_XLEN-1:0]   wdt,
  output logic [`R5P_XLEN-1:0]   rdt,
  output logic                   mal,
  output logic                   rdy,
  output logic                   ls_rtr,
  output logic                   ls_vld,
  output logic                   ls_wen,
  output logic [`R5P_AW-1:0]     ls_adr,
  output logic [3:0]             ls_ben,
  output logic [31:0]            ls_wdt,
  input  logic [31:0]            ls_rdt,
  input  logic                   ls_rdy
);

  logic                   mem_op;
  logic                   mal_raw;
  logic                   ls_req;
  logic [1:0]             off;
  logic [1:0]             ral;
  riscv_isa_pkg::lsu_f3_t rf3;

  //////////////////////////////
  // request and handshake
  //////////////////////////////

  assign mem_op = (ctl_opc == riscv_isa_pkg::LOAD) || (ctl_opc == riscv_isa_pkg::STORE);
  assign off    = adr[1:0];

  // only aligned memory ops go to the bus
  assign ls_req = mem_op & ~mal;
  assign ls_vld = ins_vld & ls_req;
  assign ls_wen = ctl_we;
  assign ls_adr = {adr[`R5P_AW-1:2], 2'b00};

  assign ls_rtr = ls_vld & ls_rdy & ~ls_wen;

  // bus ops wait for the memory, everything else goes in one cycle
  assign rdy = ~ls_req | ls_rdy;

  //////////////////////////////
  // misalignment
  //////////////////////////////

  always_comb begin
    if (ctl_we) begin
      case (ctl_f3)
        riscv_isa_pkg::SB: mal_raw = 1'b0;
        riscv_isa_pkg::SH: mal_raw = off[0];
        riscv_isa_pkg::SW: mal_raw = |off;
        // SD and friends are illegal on rv32
        default:           mal_raw = 1'b1;
      endcase
    end else begin
      case (ctl_f3)
        riscv_isa_pkg::LB, riscv_isa_pkg::LBU: mal_raw = 1'b0;
        riscv_isa_pkg::LH, riscv_isa_pkg::LHU: mal_raw = off[0];
        riscv_isa_pkg::LW:                     mal_raw = |off;
        // LD, LWU, LDU trap as well
        default:                               mal_raw = 1'b1;
      endcase
    end
  end

  // non memory opcodes never trap
  assign mal = mem_op & mal_raw;

  //////////////////////////////
  // byte enables and write data
  //////////////////////////////

  always_comb begin
    if (ctl_we) begin
      case (ctl_f3)
        riscv_isa_pkg::SB: ls_ben = 4'b0001 << off;
        riscv_isa_pkg::SH: ls_ben = 4'b0011 << off;
        riscv_isa_pkg::SW: ls_ben = 4'b1111 << off;
        default:           ls_ben = 4'b0000;
      endcase
    end else begin
      // reads fetch the whole word
      ls_ben = 4'b1111;
    end
  end

  // mask to access size, then move to the addressed lane
  always_comb begin
    case (ctl_f3)
      riscv_isa_pkg::SB: ls_wdt = (wdt & 32'h0000_00ff) << (8 * off);
      riscv_isa_pkg::SH: ls_wdt = (wdt & 32'h0000_ffff) << (8 * off);
      riscv_isa_pkg::SW: ls_wdt = wdt;
      default:           ls_wdt = wdt;
    endcase
  end

  //////////////////////////////
  // read data path
  //////////////////////////////

  // lane offset and size kept for the data returned next cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ral <= 2'd0;
      rf3 <= riscv_isa_pkg::LW;
    end else if (ls_rtr) begin
      ral <= off;
      rf3 <= ctl_f3;
    end
  end

  always_comb begin : blk_rdt
    logic [31:0] tmp;
    tmp = ls_rdt >> (8 * ral);
    case (rf3)
      riscv_isa_pkg::LB:  rdt = {{(`R5P_XLEN-8){tmp[7]}}, tmp[7:0]};
      riscv_isa_pkg::LH:  rdt = {{(`R5P_XLEN-16){tmp[15]}}, tmp[15:0]};
      riscv_isa_pkg::LBU: rdt = {{(`R5P_XLEN-8){1'b0}}, tmp[7:0]};
      riscv_isa_pkg::LHU: rdt = {{(`R5P_XLEN-16){1'b0}}, tmp[15:0]};
      // LW, and anything else passes the word
      default:            rdt = tmp;
    endcase
  end

endmodule

`default_nettype wire

/* r5p_dmem.sv */
// byte-enabled data memory, one cycle read latency
// word address wraps modulo the memory depth
// mem_stall holds off every transfer while high
`default_nettype none
`include "r5p_consts.svh"

module r5p_dmem (
  input  logic               clk,
  input  logic               rst,
  input  logic               mem_stall,
  input  logic               ls_vld,
  input  logic               ls_wen,
  input  logic [`R5P_AW-1:0] ls_adr,
  input  logic [3:0]         ls_ben,
  input  logic [31:0]        ls_wdt,
  output logic [31:0]        ls_rdt,
  output logic               ls_rdy
);

  localparam int unsigned IW = $clog2(`R5P_MEM_WORDS);

  logic [31:0]   mem [`R5P_MEM_WORDS];
  logic [IW-1:0] idx;
  logic          wtr;
  logic          rtr;

  assign ls_rdy = ~mem_stall;

  // drop the byte lane bits, keep the low word bits
  assign idx = ls_adr[IW+1:2];

  assign wtr = ls_vld & ls_rdy &  ls_wen;
  assign rtr = ls_vld & ls_rdy & ~ls_wen;

  //////////////////////////////
  // array write
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (wtr) begin
      for (int b = 0; b < 4; b++) begin
        if (ls_ben[b]) begin
          mem[idx][8*b +: 8] <= ls_wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // read data register
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ls_rdt <= 32'd0;
    end else if (rtr) begin
      ls_rdt <= mem[idx];
    end
  end

endmodule

`default_nettype wire

/* r5p_ls_writeback.sv */
// writeback of load results and misalignment traps
// both appear exactly one cycle after the instruction is consumed
// stores and other opcodes produce nothing here
`default_nettype none
`include "r5p_consts.svh"

module r5p_ls_writeback (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ins_vld,
  input  logic                 rdy,
  input  logic                 ls_rtr,
  input  logic                 mal,
  input  riscv_isa_pkg::opc_t  ctl_opc,
  input  logic [4:0]           ctl_rd,
  input  logic [`R5P_XLEN-1:0] rdt,
  output logic                 wb_vld,
  output logic                 wb_trap,
  output logic [4:0]           wb_rd,
  output logic [`R5P_XLEN-1:0] wb_dat
);

  logic mem_op;
  logic trap_nxt;

  assign mem_op = (ctl_opc == riscv_isa_pkg::LOAD) || (ctl_opc == riscv_isa_pkg::STORE);

  // memory op consumed while misaligned
  assign trap_nxt = ins_vld & rdy & mem_op & mal;

  // pending load and trap flags
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_vld  <= 1'b0;
      wb_trap <= 1'b0;
    end else begin
      wb_vld  <= ls_rtr;
      wb_trap <= trap_nxt;
    end
  end

  // destination captured with the read transfer
  always_ff @(posedge clk) begin
    if (ls_rtr) begin
      wb_rd <= ctl_rd;
    end
  end

  // extended data is already aligned by the lsu, zero when idle
  assign wb_dat = wb_vld ? rdt : '0;

endmodule

`default_nettype wire

/* r5p_ls_top.sv */
// rv32 data-memory path: decoder, lsu, data memory, writeback
// core must hold ins, rs1_val, rs2_val and ins_vld stable until rdy
// results and traps come out one cycle after the consuming cycle
`default_nettype none
`include "r5p_consts.svh"

module r5p_ls_top (
  input  logic                 clk,
  input  logic                 rst,
  input  riscv_isa_pkg::ins_t  ins,
  input  logic [`R5P_XLEN-1:0] rs1_val,
  input  logic [`R5P_XLEN-1:0] rs2_val,
  input  logic                 ins_vld,
  input  logic                 mem_stall,
  output logic                 rdy,
  output logic                 wb_vld,
  output logic                 wb_trap,
  output logic [4:0]           wb_rd,
  output logic [`R5P_XLEN-1:0] wb_dat
);

  // decoded control
  riscv_isa_pkg::opc_t    ctl_opc;
  logic                   ctl_we;
  riscv_isa_pkg::lsu_f3_t ctl_f3;
  logic [4:0]             ctl_rd;
  logic [`R5P_XLEN-1:0]   adr;
  logic [`R5P_XLEN-1:0]   wdt;

  // lsu results
  logic [`R5P_XLEN-1:0]   rdt;
  logic                   mal;
  logic                   ls_rtr;

  // memory bus
  logic                   ls_vld;
  logic                   ls_wen;
  logic [`R5P_AW-1:0]     ls_adr;
  logic [3:0]             ls_ben;
  logic [31:0]            ls_wdt;
  logic [31:0]            ls_rdt;
  logic                   ls_rdy;

  r5p_ls_decoder i_dec (
    .ins     (ins),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .ctl_opc (ctl_opc),
    .ctl_we  (ctl_we),
    .ctl_f3  (ctl_f3),
    .ctl_rd  (ctl_rd),
    .adr     (adr),
    .wdt     (wdt)
  );

  r5p_lsu i_lsu (
    .clk     (clk),
    .rst     (rst),
    .ins_vld (ins_vld),
    .ctl_opc (ctl_opc),
    .ctl_we  (ctl_we),
    .ctl_f3  (ctl_f3),
    .adr     (adr),
    .wdt     (wdt),
    .rdt     (rdt),
    .mal     (mal),
    .rdy     (rdy),
    .ls_rtr  (ls_rtr),
    .ls_vld  (ls_vld),
    .ls_wen  (ls_wen),
    .ls_adr  (ls_adr),
    .ls_ben  (ls_ben),
    .ls_wdt  (ls_wdt),
    .ls_rdt  (ls_rdt),
    .ls_rdy  (ls_rdy)
  );

  r5p_dmem i_dmem (
    .clk       (clk),
    .rst       (rst),
    .mem_stall (mem_stall),
    .ls_vld    (ls_vld),
    .ls_wen    (ls_wen),
    .ls_adr    (ls_adr),
    .ls_ben    (ls_ben),
    .ls_wdt    (ls_wdt),
    .ls_rdt    (ls_rdt),
    .ls_rdy    (ls_rdy)
  );

  r5p_ls_writeback i_wb (
    .clk     (clk),
    .rst     (rst),
    .ins_vld (ins_vld),
    .rdy     (rdy),
    .ls_rtr  (ls_rtr),
    .mal     (mal),
    .ctl_opc (ctl_opc),
    .ctl_rd  (ctl_rd),
    .rdt     (rdt),
    .wb_vld  (wb_vld),
    .wb_trap (wb_trap),
    .wb_rd   (wb_rd),
    .wb_dat  (wb_dat)
  );

endmodule

`default_nettype wire

/* tb_r5p_ls.sv */
// testbench for the rv32 load/store path
// words 0..15 are written first, every later load stays inside them
// upper address bits are random, so the word wrap is exercised as well
`default_nettype none
`include "r5p_consts.svh"

module tb_r5p_ls;

  localparam int MAX_INSTR    = 200;
  localparam int STALL_BUDGET = 8;
  localparam int NWORDS       = 16;

  logic                 clk;
  logic                 rst;
  riscv_isa_pkg::ins_t  ins;
  logic [`R5P_XLEN-1:0] rs1_val;
  logic [`R5P_XLEN-1:0] rs2_val;
  logic                 ins_vld;
  logic                 mem_stall;
  logic                 rdy;
  logic                 wb_vld;
  logic                 wb_trap;
  logic [4:0]           wb_rd;
  logic [`R5P_XLEN-1:0] wb_dat;

  logic [15:0] lfsr;
  logic [31:0] model [`R5P_MEM_WORDS];
  int          errors;
  int          checks;

  // expectation for the cycle being driven
  logic        cur_load;
  logic        cur_trap;
  logic [4:0]  cur_rd;
  logic [31:0] cur_dat;

  r5p_ls_top i_r5p_ls_top (
    .clk       (clk),
    .rst       (rst),
    .ins       (ins),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .ins_vld   (ins_vld),
    .mem_stall (mem_stall),
    .rdy       (rdy),
    .wb_vld    (wb_vld),
    .wb_trap   (wb_trap),
    .wb_rd     (wb_rd),
    .wb_dat    (wb_dat)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // random source
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[15]};
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // rv32 knows no 8-byte access and no unsigned word load
  function automatic logic ref_mal(input logic we, input logic [2:0] f3, input logic [1:0] off);
    int   size;
    logic legal;
    size  = 1 << f3[1:0];
    legal = (f3[1:0] != 2'b11) && !(f3[2] && (we || f3[1:0] == 2'b10));
    return !legal || ((off % size) != 0);
  endfunction

  // low bytes of the store data land at the byte offset
  function automatic logic [31:0] ref_merge(input logic [31:0] old, input logic [2:0] f3,
                                            input logic [1:0] off, input logic [31:0] data);
    logic [31:0] res;
    int          size;
    int          i;
    res  = old;
    size = 1 << f3[1:0];
    for (i = 0; i < size; i++) begin
      res[8*(off+i) +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] word, input logic [2:0] f3,
                                           input logic [1:0] off);
    logic [31:0] res;
    int          size;
    int          i;
    size = 1 << f3[1:0];
    res  = '0;
    for (i = 0; i < size; i++) begin
      res[8*i +: 8] = word[8*(off+i) +: 8];
    end
    // signed forms copy the top loaded bit upward
    if (!f3[2]) begin
      for (i = 8 * size; i < 32; i++) begin
        res[i] = res[8*size-1];
      end
    end
    return res;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // driver
  //////////////////////////////

  // called at a falling edge, returns at the falling edge after consumption
  task automatic issue(input logic [31:0] word, input logic [31:0] rs1, input logic [31:0] rs2,
                       input logic is_mem, input logic we, input logic [2:0] f3,
                       input logic [4:0] rd, input logic [31:0] addr);
    logic [31:0] sb;
    logic        done;
    logic        exp_rdy;
    int          idx;
    done    = 1'b0;
    idx     = (addr >> 2) % `R5P_MEM_WORDS;
    ins     = word;
    rs1_val = rs1;
    rs2_val = rs2;
    ins_vld = 1'b1;
    while (!done) begin
      take_bits(2, sb);
      // non memory ops always face a stalled memory
      mem_stall = (&sb[1:0]) | ~is_mem;
      #1;
      cur_load = 1'b0;
      cur_trap = 1'b0;
      // only a stalled memory holds back an aligned memory op
      exp_rdy = !is_mem || !mem_stall || ref_mal(we, f3, addr[1:0]);
      check("rdy", {31'd0, rdy}, {31'd0, exp_rdy});
      if (rdy) begin
        done = 1'b1;
        if (is_mem && ref_mal(we, f3, addr[1:0])) begin
          cur_trap = 1'b1;
        end else if (is_mem && we) begin
          model[idx] = ref_merge(model[idx], f3, addr[1:0], rs2);
        end else if (is_mem) begin
          cur_load = 1'b1;
          cur_rd   = rd;
          cur_dat  = ref_load(model[idx], f3, addr[1:0]);
        end
      end
      @(negedge clk);
    end
    ins_vld  = 1'b0;
    cur_load = 1'b0;
    cur_trap = 1'b0;
  endtask

  // load or store at word w of the working area, random imm and upper bits
  task automatic access(input logic we, input logic [2:0] f3, input logic [3:0] w,
                        input logic [1:0] off, input logic [31:0] data, input logic [4:0] rd);
    logic [31:0] imm;
    logic [31:0] hi;
    logic [31:0] addr;
    logic [31:0] word;
    take_bits(12, imm);
    take_bits(22, hi);
    addr = {hi[21:0], 4'b0000, w, off};
    if (we) begin
      word = {imm[11:5], 5'd11, 5'd10, f3, imm[4:0], riscv_isa_pkg::STORE};
    end else begin
      word = {imm[11:0], 5'd10, f3, rd, riscv_isa_pkg::LOAD};
    end
    // rs1 picked so that rs1 + imm hits addr
    issue(word, addr - {{20{imm[11]}}, imm[11:0]}, data, 1'b1, we, f3, rd, addr);
  endtask

  //////////////////////////////
  // compare
  //////////////////////////////

  initial begin : compare
    logic        s_rst;
    logic        s_load;
    logic        s_trap;
    logic [4:0]  s_rd;
    logic [31:0] s_dat;
    forever begin
      @(posedge clk);
      s_rst  = rst;
      s_load = cur_load;
      s_trap = cur_trap;
      s_rd   = cur_rd;
      s_dat  = cur_dat;
      @(negedge clk);
      if (!s_rst) begin
        check("wb_vld", {31'd0, wb_vld}, {31'd0, s_load});
        check("wb_trap", {31'd0, wb_trap}, {31'd0, s_trap});
        if (s_load) begin
          check("wb_rd", {27'd0, wb_rd}, {27'd0, s_rd});
          check("wb_dat", wb_dat, s_dat);
        end
      end
    end
  end

  initial begin : watchdog
    #(MAX_INSTR * STALL_BUDGET * 20 + 2000);
    $display("watchdog: the run timed out before all instructions were consumed");
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin : stimulus
    logic [31:0] v_w;
    logic [31:0] v_f;
    logic [31:0] v_o;
    logic [31:0] v_d;
    logic [31:0] v_r;
    logic [2:0]  f3;
    errors    = 0;
    checks    = 0;
    lfsr      = 16'd97;
    rst       = 1'b1;
    ins       = '0;
    rs1_val   = '0;
    rs2_val   = '0;
    ins_vld   = 1'b0;
    mem_stall = 1'b0;
    cur_load  = 1'b0;
    cur_trap  = 1'b0;
    cur_rd    = '0;
    cur_dat   = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // known contents for the working words
    for (int w = 0; w < NWORDS; w++) begin
      take_bits(32, v_d);
      access(1'b1, riscv_isa_pkg::SW, w[3:0], 2'd0, v_d, 5'd0);
    end

    // stores of every size, each read back as a word
    for (int n = 0; n < 40; n++) begin
      take_bits(4, v_w);
      take_bits(2, v_f);
      take_bits(2, v_o);
      take_bits(32, v_d);
      take_bits(5, v_r);
      f3 = (v_f[1:0] == 2'd0) ? riscv_isa_pkg::SB :
           (v_f[1:0] == 2'd1) ? riscv_isa_pkg::SH : riscv_isa_pkg::SW;
      if (f3 == riscv_isa_pkg::SH) v_o[0] = 1'b0;
      if (f3 == riscv_isa_pkg::SW) v_o[1:0] = 2'd0;
      access(1'b1, f3, v_w[3:0], v_o[1:0], v_d, 5'd0);
      access(1'b0, riscv_isa_pkg::LW, v_w[3:0], 2'd0, 32'd0, v_r[4:0]);
    end

    // every load form at every legal offset
    for (int n = 0; n < 4; n++) begin
      for (int k = 0; k < 5; k++) begin
        f3 = (k == 0) ? riscv_isa_pkg::LB  : (k == 1) ? riscv_isa_pkg::LBU :
             (k == 2) ? riscv_isa_pkg::LH  : (k == 3) ? riscv_isa_pkg::LHU : riscv_isa_pkg::LW;
        for (int o = 0; o < 4; o++) begin
          if (!ref_mal(1'b0, f3, o[1:0])) begin
            take_bits(4, v_w);
            take_bits(5, v_r);
            access(1'b0, f3, v_w[3:0], o[1:0], 32'd0, v_r[4:0]);
          end
        end
      end
    end

    // misaligned halfwords and words trap, the word reads back unchanged
    for (int we = 0; we < 2; we++) begin
      for (int f = 1; f < 3; f++) begin
        for (int o = 1; o < 4; o++) begin
          if (ref_mal(we[0], f[2:0], o[1:0])) begin
            take_bits(4, v_w);
            take_bits(32, v_d);
            access(we[0], f[2:0], v_w[3:0], o[1:0], v_d, 5'd3);
            access(1'b0, riscv_isa_pkg::LW, v_w[3:0], 2'd0, 32'd0, 5'd4);
          end
        end
      end
    end

    // rv64 encodings are illegal here
    access(1'b0, 3'b011, 4'd2, 2'd0, 32'd0, 5'd5);
    access(1'b1, 3'b011, 4'd2, 2'd0, 32'hdead_beef, 5'd0);

    // op-type opcode, consumed at once with no writeback
    for (int n = 0; n < 8; n++) begin
      take_bits(25, v_d);
      take_bits(32, v_r);
      issue({v_d[24:0], 7'b011_0011}, v_r, v_d, 1'b0, 1'b0, 3'd0, 5'd0, 32'd0);
    end

    // let the last writeback be compared
    repeat (2) @(negedge clk);
    #1;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
riscv_isa_pkg.sv
r5p_ctl_pkg.sv
r5p_ls_decoder.sv
r5p_lsu.sv
r5p_dmem.sv
r5p_ls_writeback.sv
r5p_ls_top.sv
tb_r5p_ls.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load/store path testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -f files.f --top-module tb_r5p_ls -o sim_r5p_ls > build.log 2>&1 \
  && ./obj_dir/sim_r5p_ls > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "^ALL TESTS PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
